// ==== bcd_step.sv ====
`timescale 1ns/1ps

module bcd_step
  import rtc_edit_pkg::*;
(
  input  logic [7:0] value,
  input  step_req_t  req,
  output logic [7:0] result
);

  logic [3:0] tens;
  logic [3:0] units;

  assign tens  = value[7:4];
  assign units = value[3:0];

  always_comb begin
    // No request, write back unchanged
    result = value;
    if (req.up) begin
      // Up wins over down
      if (value >= bcd_limit) begin
        result = 8'h00;
      end else if (units == 4'd9) begin
        // Carry into tens
        result[7:4] = tens + 4'd1;
        result[3:0] = 4'd0;
      end else begin
        result[3:0] = units + 4'd1;
      end
    end else if (req.down) begin
      if (value == 8'h00) begin
        // Floor at zero
        result = 8'h00;
      end else if (units == 4'd0) begin
        // Borrow from tens
        result[7:4] = tens - 4'd1;
        result[3:0] = 4'd9;
      end else begin
        result[3:0] = units - 4'd1;
      end
    end
  end

endmodule

// ==== edit_request_bank.sv ====
`timescale 1ns/1ps

module edit_request_bank
  import rtc_edit_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  edit_cmd_t  cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  field_idx_t rd_field,
  output step_req_t  req,
  input  logic       clr_en,
  input  field_idx_t clr_field
);

  // One pair of flags per field
  logic [num_fields:1] up_q;
  logic [num_fields:1] down_q;

  logic cmd_hit;
  logic clr_hit;
  logic rd_hit;

  // Field numbers outside 1..10 are dropped
  assign cmd_hit = cmd_valid && (cmd.field >= 4'd1) && (cmd.field <= 4'(num_fields));
  assign clr_hit = clr_en && (clr_field >= 4'd1) && (clr_field <= 4'(num_fields));
  assign rd_hit  = (rd_field >= 4'd1) && (rd_field <= 4'(num_fields));

  // Always able to take a command
  assign cmd_ready = 1'b1;

  //////////////////////////////
  // Flag update
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      up_q   <= '0;
      down_q <= '0;
    end else begin
      if (cmd_hit) begin
        if (cmd.up) begin
          up_q[cmd.field] <= 1'b1;
        end else begin
          down_q[cmd.field] <= 1'b1;
        end
      end
      // Placed last so a clear overrides a same-cycle command
      if (clr_hit) begin
        up_q[clr_field]   <= 1'b0;
        down_q[clr_field] <= 1'b0;
      end
    end
  end

  // Read port for the field under edit
  always_comb begin
    req = '0;
    if (rd_hit) begin
      req.up   = up_q[rd_field];
      req.down = down_q[rd_field];
    end
  end

endmodule

// ==== field_value_store.sv ====
`timescale 1ns/1ps

module field_value_store
  import rtc_edit_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  field_idx_t rd_field,
  output logic [7:0] rd_data,
  input  logic       wr_en,
  input  field_idx_t wr_field,
  input  logic [7:0] wr_data
);

  // Shadow of the chip registers, last value written
  logic [7:0] mem [1:num_fields];

  logic wr_hit;
  logic rd_hit;

  assign wr_hit = wr_en && (wr_field >= 4'd1) && (wr_field <= 4'(num_fields));
  assign rd_hit = (rd_field >= 4'd1) && (rd_field <= 4'(num_fields));

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      // Chip is never read back, so start from 00
      for (int i = 1; i <= num_fields; i++) begin
        mem[i] <= 8'h00;
      end
    end else if (wr_hit) begin
      mem[wr_field] <= wr_data;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  always_comb begin
    rd_data = 8'h00;
    if (rd_hit) begin
      rd_data = mem[rd_field];
    end
  end

endmodule

// ==== rtc_edit_input.txt ====
# c <field> <up 1, down 0> | s <test> <stall percent> <sweeps, requests given before each>
# e <addr> <data> ten times, hex, expected writes of the last sweep
s no_req 0 1
e 21 00 22 00 23 00 24 00 25 00 26 00 27 00 41 00 42 00 43 00
c 1 1
c 3 1
c 8 1
c 10 1
s up_several 25 1
e 21 01 22 00 23 01 24 00 25 00 26 00 27 00 41 01 42 00 43 01
c 1 1
c 2 1
s carry 0 9
e 21 10 22 09 23 01 24 00 25 00 26 00 27 00 41 01 42 00 43 01
c 5 1
s up_to_59 0 59
e 21 10 22 09 23 01 24 00 25 59 26 00 27 00 41 01 42 00 43 01
c 5 1
c 6 0
c 1 1
c 1 0
c 2 0
c 3 0
s wrap_floor_both 0 1
e 21 11 22 08 23 00 24 00 25 00 26 00 27 00 41 01 42 00 43 01
s consumed 0 1
e 21 11 22 08 23 00 24 00 25 00 26 00 27 00 41 01 42 00 43 01
s stall_hold 80 1
e 21 11 22 08 23 00 24 00 25 00 26 00 27 00 41 01 42 00 43 01
c 1 0
c 4 1
c 8 0
c 10 1
s stall_step 80 2
e 21 09 22 08 23 00 24 02 25 00 26 00 27 00 41 00 42 00 43 03

// ==== rtc_edit_pkg.sv ====
package rtc_edit_pkg;

  //////////////////////////////
  // Field and value limits
  //////////////////////////////

  // Editable time and date fields, numbered from 1
  localparam int num_fields = 10;

  // Highest legal BCD value, shared by all fields
  localparam logic [7:0] bcd_limit = 8'h59;

  //////////////////////////////
  // Chip register map
  //////////////////////////////

  // Fields 1 to 7 sit in the time block of the chip
  localparam int num_lo_fields = 7;
  localparam logic [7:0] field_addr_base_lo = 8'h21;

  // Fields 8 to 10 sit in the date block
  localparam logic [7:0] field_addr_base_hi = 8'h41;

  //////////////////////////////
  // Shared types
  //////////////////////////////

  // Field number 1 to 10, zero never used
  typedef logic [3:0] field_idx_t;

  // Step request from the user side
  typedef struct packed {
    field_idx_t field;
    logic       up;     // 0 means down
  } edit_cmd_t;

  // One register write toward the clock chip
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } rtc_write_t;

  // Pending steps for one field
  typedef struct packed {
    logic up;
    logic down;
  } step_req_t;

endpackage

// ==== rtc_edit_sequencer.sv ====
`timescale 1ns/1ps

module rtc_edit_sequencer
  import rtc_edit_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  output logic       busy,
  output logic       done,
  output field_idx_t rd_field,
  input  logic [7:0] rd_data,
  input  step_req_t  req,
  output rtc_write_t wr,
  output logic       wr_valid,
  input  logic       wr_ready,
  output logic       st_wr_en,
  output field_idx_t st_wr_field,
  output logic [7:0] st_wr_data,
  output logic       clr_en,
  output field_idx_t clr_field
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_finish
  } state_t;

  state_t     state;
  field_idx_t cur_field;
  logic [7:0] step_value;
  logic [7:0] field_addr;
  logic       xfer;

  // Value after the pending step
  bcd_step bcd_step_i (
    .value  (rd_data),
    .req    (req),
    .result (step_value)
  );

  //////////////////////////////
  // Register address
  //////////////////////////////

  // Time block, then date block
  always_comb begin
    if (cur_field <= 4'(num_lo_fields)) begin
      field_addr = field_addr_base_lo + 8'(cur_field) - 8'd1;
    end else begin
      field_addr = field_addr_base_hi + 8'(cur_field) - 8'(num_lo_fields + 1);
    end
  end

  // Transfer completes on this edge
  assign xfer = (state == st_write) && wr_ready;

  //////////////////////////////
  // Sweep FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      cur_field <= 4'd1;
    end else begin
      case (state)
        st_idle: begin
          // start only counts here
          if (start) begin
            cur_field <= 4'd1;
            state     <= st_read;
          end
        end
        st_read: begin
          state <= st_write;
        end
        st_write: begin
          // Hold everything until the chip side takes it
          if (wr_ready) begin
            if (cur_field == 4'(num_fields)) begin
              state <= st_finish;
            end else begin
              cur_field <= cur_field + 4'd1;
              state     <= st_read;
            end
          end
        end
        st_finish: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Payload captured in the read cycle, stable through the write
  always_ff @(posedge clk) begin
    if (state == st_read) begin
      wr.addr <= field_addr;
      wr.data <= step_value;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign busy     = (state == st_read) || (state == st_write);
  assign done     = (state == st_finish);
  assign wr_valid = (state == st_write);
  assign rd_field = cur_field;

  // Shadow update and request clear ride on the transfer
  assign st_wr_en    = xfer;
  assign st_wr_field = cur_field;
  assign st_wr_data  = wr.data;
  assign clr_en      = xfer;
  assign clr_field   = cur_field;

endmodule

// ==== rtc_edit_sva.sv ====
`timescale 1ns/1ps

module rtc_edit_sva
  import rtc_edit_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       busy,
  input logic       done,
  input rtc_write_t wr,
  input logic       wr_valid,
  input logic       wr_ready
);

  // Payload held while the chip side stalls
  wr_stable_a: assert property (@(posedge clk) disable iff (reset)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr))
    else $error("wr changed or wr_valid dropped before the transfer");

  // One cycle end marker
  done_pulse_a: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done high for more than one cycle");

  // No write outside a sweep
  valid_in_sweep_a: assert property (@(posedge clk) disable iff (reset)
    wr_valid |-> busy)
    else $error("wr_valid high while busy is low");

endmodule

bind rtc_edit_sequencer rtc_edit_sva rtc_edit_sva_i (.*);

// ==== rtc_edit_top.sv ====
`timescale 1ns/1ps

module rtc_edit_top
  import rtc_edit_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  edit_cmd_t  cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  logic       start,
  output logic       busy,
  output logic       done,
  output rtc_write_t wr,
  output logic       wr_valid,
  input  logic       wr_ready
);

  // Read side, driven by the sequencer
  field_idx_t rd_field;
  logic [7:0] rd_data;
  step_req_t  req;

  // Commit side
  logic       st_wr_en;
  field_idx_t st_wr_field;
  logic [7:0] st_wr_data;
  logic       clr_en;
  field_idx_t clr_field;

  edit_request_bank edit_request_bank_i (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rd_field  (rd_field),
    .req       (req),
    .clr_en    (clr_en),
    .clr_field (clr_field)
  );

  field_value_store field_value_store_i (
    .clk      (clk),
    .reset    (reset),
    .rd_field (rd_field),
    .rd_data  (rd_data),
    .wr_en    (st_wr_en),
    .wr_field (st_wr_field),
    .wr_data  (st_wr_data)
  );

  rtc_edit_sequencer rtc_edit_sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .rd_field    (rd_field),
    .rd_data     (rd_data),
    .req         (req),
    .wr          (wr),
    .wr_valid    (wr_valid),
    .wr_ready    (wr_ready),
    .st_wr_en    (st_wr_en),
    .st_wr_field (st_wr_field),
    .st_wr_data  (st_wr_data),
    .clr_en      (clr_en),
    .clr_field   (clr_field)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rtc_edit -f tb.f
out=$(./obj_dir/Vtb_rtc_edit || true)
echo "$out"
if echo "$out" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi

// ==== tb.f ====
rtc_edit_pkg.sv
bcd_step.sv
edit_request_bank.sv
field_value_store.sv
rtc_edit_sequencer.sv
rtc_edit_top.sv
rtc_edit_sva.sv
tb_rtc_edit.sv

// ==== tb_rtc_edit.sv ====
`timescale 1ns/1ps

module tb_rtc_edit
  import rtc_edit_pkg::*;
();

  localparam int reset_cycles = 10;
  // Sweeps in rtc_edit_input.txt, with some room
  localparam int sweep_budget = 80;
  localparam int cycle_limit  = reset_cycles + sweep_budget * num_fields * 20;

  logic       clk;
  logic       reset;
  edit_cmd_t  cmd;
  logic       cmd_valid;
  logic       cmd_ready;
  logic       start;
  logic       busy;
  logic       done;
  rtc_write_t wr;
  logic       wr_valid;
  logic       wr_ready;

  integer     seed;
  int         stall_pct;
  int         cycle_count;
  int         pass_count;
  int         fail_count;
  int         done_count;
  rtc_write_t got[$];
  edit_cmd_t  pending[$];

  rtc_edit_top rtc_edit_top_i (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .wr        (wr),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready)
  );

  always #5 clk = ~clk;

  // Chip side back-pressure
  always @(posedge clk) begin
    wr_ready <= ($unsigned($random(seed)) % 100) >= stall_pct;
  end

  //////////////////////////////
  // Monitor and watchdog
  //////////////////////////////

  always @(posedge clk) begin
    if (!reset && wr_valid && wr_ready) begin
      got.push_back(wr);
    end
    if (!reset && done) begin
      done_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, a sweep did not finish", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_count++;
      $display("[FAIL] %s expected %0h actual %0h", label, expected, actual);
    end else begin
      pass_count++;
    end
  endtask

  task automatic send_cmd(input edit_cmd_t c);
    @(posedge clk);
    cmd       <= c;
    cmd_valid <= 1'b1;
    @(posedge clk);
    cmd_valid <= 1'b0;
    check_value("cmd_ready on command", 1, 32'(cmd_ready));
  endtask

  task automatic run_sweep(input string test);
    got.delete();
    done_count = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    // Extra start once the sweep is running
    while (!busy) @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!done) @(posedge clk);
    repeat (3) @(posedge clk);
    check_value({test, " write count"}, num_fields, got.size());
    check_value({test, " done pulses"}, 1, done_count);
    check_value({test, " busy after done"}, 0, 32'(busy));
  endtask

  initial begin
    int           fd;
    int           code;
    int           field;
    int           up;
    int           reps;
    int           fails_before;
    logic [7:0]   kind;
    logic [191:0] name;
    logic [1023:0] rest;
    logic [7:0]   addr;
    logic [7:0]   data;
    edit_cmd_t    c;
    rtc_write_t   actual;
    string        test;

    clk         = 1'b0;
    reset       = 1'b1;
    cmd         = '0;
    cmd_valid   = 1'b0;
    start       = 1'b0;
    wr_ready    = 1'b0;
    seed        = 32'h7ae6;
    stall_pct   = 0;
    cycle_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    done_count  = 0;
    test        = "none";

    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    // Outputs idle after reset
    check_value("busy after reset", 0, 32'(busy));
    check_value("done after reset", 0, 32'(done));
    check_value("wr_valid after reset", 0, 32'(wr_valid));

    fd = $fopen("rtc_edit_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open rtc_edit_input.txt");
      fail_count++;
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        if (kind == "#") begin
          code = $fgets(rest, fd);
        end else if (kind == "c") begin
          code = $fscanf(fd, "%d %d", field, up);
          c.field = 4'(field);
          c.up    = up[0];
          pending.push_back(c);
        end else if (kind == "s") begin
          code = $fscanf(fd, "%s %d %d", name, stall_pct, reps);
          test = $sformatf("%0s", name);
          fails_before = fail_count;
          // Requests are given again before every sweep
          for (int r = 0; r < reps; r++) begin
            foreach (pending[i]) begin
              send_cmd(pending[i]);
            end
            run_sweep(test);
          end
          pending.delete();
        end else if (kind == "e") begin
          for (int i = 0; i < num_fields; i++) begin
            code = $fscanf(fd, "%h %h", addr, data);
            actual = '1;
            if (i < got.size()) begin
              actual = got[i];
            end
            check_value($sformatf("%s write %0d addr", test, i + 1), 32'(addr),
                        32'(actual.addr));
            check_value($sformatf("%s write %0d data", test, i + 1), 32'(data),
                        32'(actual.data));
          end
          if (fail_count == fails_before) begin
            $display("Test %s: ok", test);
          end else begin
            $display("Test %s: %0d errors", test, fail_count - fails_before);
          end
        end else begin
          $display("Unknown line kind in rtc_edit_input.txt");
          fail_count++;
        end
      end
      $fclose(fd);
    end

    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
